/* source/csr_pkg.sv */
package csr_pkg;

  // register value, address, cause and write-select widths
  typedef logic [63:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  csr_cause_t;
  typedef logic [11:0] csr_sel_t;

  // floating-point CSRs
  localparam csr_addr_t CSR_FFLAGS   = 12'h001;
  localparam csr_addr_t CSR_FRM      = 12'h002;
  localparam csr_addr_t CSR_FCSR     = 12'h003;

  // supervisor CSRs
  localparam csr_addr_t CSR_SSTATUS  = 12'h100;
  localparam csr_addr_t CSR_SEPC     = 12'h141;

  // machine CSRs
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;

  // bit positions in the one-hot write select
  localparam int SEL_FFLAGS   = 0;
  localparam int SEL_FRM      = 1;
  localparam int SEL_FCSR     = 2;
  localparam int SEL_SSTATUS  = 3;
  localparam int SEL_SEPC     = 4;
  localparam int SEL_MSTATUS  = 5;
  localparam int SEL_MIE      = 6;
  localparam int SEL_MTVEC    = 7;
  localparam int SEL_MEPC     = 8;
  localparam int SEL_MCAUSE   = 9;
  localparam int SEL_MTVAL    = 10;
  localparam int SEL_MINSTRET = 11;

  // SXL and UXL both set to 64-bit
  localparam csr_data_t MSTATUS_RESET      = 64'h0000_000A_0000_0000;

  // SIE, SPIE, UBE, SPP, FS, XS, SUM, MXR, UXL and SD
  localparam csr_data_t SSTATUS_READ_MASK  = 64'h8000_0003_000D_E162;
  // SIE, SPIE, SPP, FS, SUM and MXR
  localparam csr_data_t SSTATUS_WRITE_MASK = 64'h0000_0000_000C_6122;

  // SSIP..MEIP style enables, odd bits 1 to 11
  localparam csr_data_t MIE_MASK           = 64'h0000_0000_0000_0AAA;
  localparam csr_data_t FFLAGS_MASK        = 64'h0000_0000_0000_001F;

  // exception causes that carry a trap value
  localparam csr_cause_t CAUSE_MISALIGNED_FETCH = 5'd0;
  localparam csr_cause_t CAUSE_FAULT_FETCH      = 5'd1;
  localparam csr_cause_t CAUSE_MISALIGNED_LOAD  = 5'd4;
  localparam csr_cause_t CAUSE_FAULT_LOAD       = 5'd5;
  localparam csr_cause_t CAUSE_MISALIGNED_STORE = 5'd6;
  localparam csr_cause_t CAUSE_FAULT_STORE      = 5'd7;

endpackage

/* source/csr_write_stage.sv */
`timescale 1ns/1ps

module csr_write_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush_i,
  input  logic               wr_en_i,
  input  csr_pkg::csr_addr_t wr_addr_i,
  input  csr_pkg::csr_data_t wr_data_i,
  input  logic               commit_i,
  output csr_pkg::csr_sel_t  wr_sel_o,
  output csr_pkg::csr_data_t wr_data_o
);
  import csr_pkg::*;

  csr_addr_t pend_addr;
  csr_data_t pend_data;
  logic      pend_valid;

  // pending write waits here until the CSR instruction retires
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      pend_addr <= wr_addr_i;
      pend_data <= wr_data_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pend_valid <= 1'b0;
    else if (wr_en_i)
      pend_valid <= 1'b1;
    else if (flush_i)
      pend_valid <= 1'b0;
  end

  // commit decodes the older pending entry, not this cycle's wr_en_i
  always_comb
  begin
    wr_sel_o = '0;
    if (commit_i && pend_valid)
    begin
      case (pend_addr)
        CSR_FFLAGS:   wr_sel_o[SEL_FFLAGS]   = 1'b1;
        CSR_FRM:      wr_sel_o[SEL_FRM]      = 1'b1;
        CSR_FCSR:     wr_sel_o[SEL_FCSR]     = 1'b1;
        CSR_SSTATUS:  wr_sel_o[SEL_SSTATUS]  = 1'b1;
        CSR_SEPC:     wr_sel_o[SEL_SEPC]     = 1'b1;
        CSR_MSTATUS:  wr_sel_o[SEL_MSTATUS]  = 1'b1;
        CSR_MIE:      wr_sel_o[SEL_MIE]      = 1'b1;
        CSR_MTVEC:    wr_sel_o[SEL_MTVEC]    = 1'b1;
        CSR_MEPC:     wr_sel_o[SEL_MEPC]     = 1'b1;
        CSR_MCAUSE:   wr_sel_o[SEL_MCAUSE]   = 1'b1;
        CSR_MTVAL:    wr_sel_o[SEL_MTVAL]    = 1'b1;
        CSR_MINSTRET: wr_sel_o[SEL_MINSTRET] = 1'b1;
        // mhartid and unknown addresses write nothing
        default:      wr_sel_o               = '0;
      endcase
    end
  end

  assign wr_data_o = pend_data;

  // at most one register is written per commit
  a_sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_sel_o))
    else $error("csr_write_stage: write select not one-hot: %b", wr_sel_o);

endmodule

/* source/csr_state.sv */
`timescale 1ns/1ps

module csr_state #(
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                               clk,
  input  logic                               reset,
  input  csr_pkg::csr_sel_t                  wr_sel_i,
  input  csr_pkg::csr_data_t                 wr_data_i,
  input  logic                               exception_i,
  input  csr_pkg::csr_data_t                 exc_pc_i,
  input  csr_pkg::csr_cause_t                exc_cause_i,
  input  csr_pkg::csr_data_t                 ld_addr_i,
  input  csr_pkg::csr_data_t                 st_addr_i,
  input  logic                               sret_i,
  input  logic [$clog2(COMMIT_WIDTH+1)-1:0]  commit_count_i,
  input  csr_pkg::csr_data_t                 fflags_i,
  output csr_pkg::csr_data_t                 fcsr_o,
  output csr_pkg::csr_data_t                 mstatus_o,
  output csr_pkg::csr_data_t                 sepc_o,
  output csr_pkg::csr_data_t                 mie_o,
  output csr_pkg::csr_data_t                 mtvec_o,
  output csr_pkg::csr_data_t                 mepc_o,
  output csr_pkg::csr_data_t                 mcause_o,
  output csr_pkg::csr_data_t                 mtval_o,
  output csr_pkg::csr_data_t                 minstret_o,
  output csr_pkg::csr_data_t                 epc_o
);
  import csr_pkg::*;

  csr_data_t fcsr;
  csr_data_t mstatus;
  csr_data_t sepc;
  csr_data_t mie;
  csr_data_t mtvec;
  csr_data_t mepc;
  csr_data_t mcause;
  csr_data_t mtval;
  csr_data_t minstret;
  csr_data_t mtval_trap;
  csr_data_t minstret_inc;

  // trap value depends on which unit raised the fault
  always_comb
  begin
    case (exc_cause_i)
      CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH: mtval_trap = exc_pc_i;
      CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD:   mtval_trap = ld_addr_i;
      CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE: mtval_trap = st_addr_i;
      default:                                   mtval_trap = mtval;
    endcase
  end

  // the trapping instruction counts as retired too
  assign minstret_inc = csr_data_t'(commit_count_i) + csr_data_t'(exception_i);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fcsr     <= '0;
      mstatus  <= MSTATUS_RESET;
      sepc     <= '0;
      mie      <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      minstret <= '0;
    end
    else
    begin
      // fflags is fcsr[4:0], frm is fcsr[7:5]
      if (wr_sel_i[SEL_FFLAGS])
        fcsr <= {56'b0, fcsr[7:5], wr_data_i[4:0]};
      else if (wr_sel_i[SEL_FRM])
        fcsr <= {56'b0, wr_data_i[2:0], fcsr[4:0]};
      else if (wr_sel_i[SEL_FCSR])
        fcsr <= {56'b0, wr_data_i[7:0]};
      else
        fcsr <= fcsr | (fflags_i & FFLAGS_MASK);

      // sstatus is a restricted view of mstatus
      if (wr_sel_i[SEL_MSTATUS])
        mstatus <= wr_data_i;
      else if (wr_sel_i[SEL_SSTATUS])
        mstatus <= (wr_data_i & SSTATUS_WRITE_MASK) | (mstatus & ~SSTATUS_WRITE_MASK);

      if (wr_sel_i[SEL_MIE])
        mie <= wr_data_i & MIE_MASK;

      if (wr_sel_i[SEL_MTVEC])
        mtvec <= wr_data_i;

      if (wr_sel_i[SEL_SEPC])
        sepc <= {wr_data_i[63:1], 1'b0};
      else if (exception_i)
        sepc <= exc_pc_i;

      if (wr_sel_i[SEL_MEPC])
        mepc <= {wr_data_i[63:1], 1'b0};
      else if (exception_i)
        mepc <= exc_pc_i;

      if (wr_sel_i[SEL_MCAUSE])
        mcause <= wr_data_i;
      else if (exception_i)
        mcause <= csr_data_t'(exc_cause_i);

      if (wr_sel_i[SEL_MTVAL])
        mtval <= wr_data_i;
      else if (exception_i)
        mtval <= mtval_trap;

      if (wr_sel_i[SEL_MINSTRET])
        minstret <= wr_data_i;
      else
        minstret <= minstret + minstret_inc;
    end
  end

  assign epc_o      = sret_i ? sepc : mepc;
  assign fcsr_o     = fcsr;
  assign mstatus_o  = mstatus;
  assign sepc_o     = sepc;
  assign mie_o      = mie;
  assign mtvec_o    = mtvec;
  assign mepc_o     = mepc;
  assign mcause_o   = mcause;
  assign mtval_o    = mtval;
  assign minstret_o = minstret;

  // also catches a misaligned exception PC coming from the core
  a_mepc_aligned: assert property (@(posedge clk) disable iff (reset) mepc[0] == 1'b0)
    else $error("csr_state: mepc bit 0 set, mepc=%h", mepc);

endmodule

/* source/csr_read_select.sv */
`timescale 1ns/1ps

module csr_read_select (
  input  csr_pkg::csr_addr_t addr_i,
  input  csr_pkg::csr_data_t hart_id_i,
  input  csr_pkg::csr_data_t fcsr_i,
  input  csr_pkg::csr_data_t mstatus_i,
  input  csr_pkg::csr_data_t sepc_i,
  input  csr_pkg::csr_data_t mie_i,
  input  csr_pkg::csr_data_t mtvec_i,
  input  csr_pkg::csr_data_t mepc_i,
  input  csr_pkg::csr_data_t mcause_i,
  input  csr_pkg::csr_data_t mtval_i,
  input  csr_pkg::csr_data_t minstret_i,
  output csr_pkg::csr_data_t data_o,
  output logic               known_o
);
  import csr_pkg::*;

  // architectural view, used both for the read port and the checkpoint compare
  always_comb
  begin
    known_o = 1'b1;
    case (addr_i)
      CSR_FFLAGS:   data_o = {59'b0, fcsr_i[4:0]};
      CSR_FRM:      data_o = {61'b0, fcsr_i[7:5]};
      CSR_FCSR:     data_o = {56'b0, fcsr_i[7:0]};
      CSR_SSTATUS:  data_o = mstatus_i & SSTATUS_READ_MASK;
      CSR_SEPC:     data_o = sepc_i;
      CSR_MSTATUS:  data_o = mstatus_i;
      CSR_MIE:      data_o = mie_i;
      CSR_MTVEC:    data_o = mtvec_i;
      CSR_MEPC:     data_o = mepc_i;
      CSR_MCAUSE:   data_o = mcause_i;
      CSR_MTVAL:    data_o = mtval_i;
      CSR_MINSTRET: data_o = minstret_i;
      CSR_MHARTID:  data_o = hart_id_i;
      default:
      begin
        data_o  = '0;
        known_o = 1'b0;
      end
    endcase
  end

endmodule

/* source/csr_atomic_check.sv */
`timescale 1ns/1ps

module csr_atomic_check (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd_en_i,
  input  csr_pkg::csr_addr_t rd_addr_i,
  input  csr_pkg::csr_data_t rd_data_i,
  input  logic               flush_i,
  input  logic               commit_i,
  output csr_pkg::csr_addr_t chk_addr_o,
  input  csr_pkg::csr_data_t chk_view_i,
  input  logic               chk_known_i,
  output logic               atomic_vio_o
);
  import csr_pkg::*;

  logic      chk_valid;
  csr_addr_t chk_addr;
  csr_data_t chk_data;

  // snapshot of what the CSR instruction saw
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr <= rd_addr_i;
      chk_data <= rd_data_i;
    end
  end

  // the instruction leaves the window when it commits or is squashed
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      chk_valid <= 1'b0;
    else if (rd_en_i)
      chk_valid <= 1'b1;
    else if (flush_i || commit_i)
      chk_valid <= 1'b0;
  end

  assign chk_addr_o = chk_addr;

  // retire logic replays the instruction when this is high
  assign atomic_vio_o = chk_valid && chk_known_i && (chk_view_i != chk_data);

  // leaving the window without a new read drops the flag on the next cycle
  a_vio_clears: assert property (@(posedge clk) disable iff (reset)
    (flush_i || commit_i) && !rd_en_i |=> !atomic_vio_o)
    else $error("csr_atomic_check: violation still flagged after flush or commit");

endmodule

/* source/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               flush_i,
  input  logic                               wr_en_i,
  input  csr_pkg::csr_addr_t                 wr_addr_i,
  input  csr_pkg::csr_data_t                 wr_data_i,
  input  logic                               commit_i,
  input  logic                               rd_en_i,
  input  csr_pkg::csr_addr_t                 rd_addr_i,
  output csr_pkg::csr_data_t                 rd_data_o,
  input  logic                               exception_i,
  input  csr_pkg::csr_data_t                 exc_pc_i,
  input  csr_pkg::csr_cause_t                exc_cause_i,
  input  csr_pkg::csr_data_t                 ld_addr_i,
  input  csr_pkg::csr_data_t                 st_addr_i,
  input  logic                               sret_i,
  input  logic [$clog2(COMMIT_WIDTH+1)-1:0]  commit_count_i,
  input  csr_pkg::csr_data_t                 fflags_i,
  input  csr_pkg::csr_data_t                 hart_id_i,
  output logic                               atomic_vio_o,
  output csr_pkg::csr_data_t                 epc_o,
  output csr_pkg::csr_data_t                 evec_o,
  output csr_pkg::csr_data_t                 status_o,
  output csr_pkg::csr_data_t                 frm_o
);

  csr_pkg::csr_sel_t  wr_sel;
  csr_pkg::csr_data_t wr_data;
  csr_pkg::csr_data_t fcsr;
  csr_pkg::csr_data_t mstatus;
  csr_pkg::csr_data_t sepc;
  csr_pkg::csr_data_t mie;
  csr_pkg::csr_data_t mtvec;
  csr_pkg::csr_data_t mepc;
  csr_pkg::csr_data_t mcause;
  csr_pkg::csr_data_t mtval;
  csr_pkg::csr_data_t minstret;
  csr_pkg::csr_addr_t chk_addr;
  csr_pkg::csr_data_t chk_view;
  logic               chk_known;

  // decode: pending write, released on commit
  csr_write_stage u_write_stage (
    .clk       (clk),
    .reset     (reset),
    .flush_i   (flush_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .commit_i  (commit_i),
    .wr_sel_o  (wr_sel),
    .wr_data_o (wr_data)
  );

  // execute: architectural state
  csr_state #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_state (
    .clk            (clk),
    .reset          (reset),
    .wr_sel_i       (wr_sel),
    .wr_data_i      (wr_data),
    .exception_i    (exception_i),
    .exc_pc_i       (exc_pc_i),
    .exc_cause_i    (exc_cause_i),
    .ld_addr_i      (ld_addr_i),
    .st_addr_i      (st_addr_i),
    .sret_i         (sret_i),
    .commit_count_i (commit_count_i),
    .fflags_i       (fflags_i),
    .fcsr_o         (fcsr),
    .mstatus_o      (mstatus),
    .sepc_o         (sepc),
    .mie_o          (mie),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc),
    .mcause_o       (mcause),
    .mtval_o        (mtval),
    .minstret_o     (minstret),
    .epc_o          (epc_o)
  );

  // result: read port, unknown addresses already read as zero
  csr_read_select u_rd_select (
    .addr_i     (rd_addr_i),
    .hart_id_i  (hart_id_i),
    .fcsr_i     (fcsr),
    .mstatus_i  (mstatus),
    .sepc_i     (sepc),
    .mie_i      (mie),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .mcause_i   (mcause),
    .mtval_i    (mtval),
    .minstret_i (minstret),
    .data_o     (rd_data_o),
    .known_o    ()
  );

  // result: current view of the checkpointed register
  csr_read_select u_chk_select (
    .addr_i     (chk_addr),
    .hart_id_i  (hart_id_i),
    .fcsr_i     (fcsr),
    .mstatus_i  (mstatus),
    .sepc_i     (sepc),
    .mie_i      (mie),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .mcause_i   (mcause),
    .mtval_i    (mtval),
    .minstret_i (minstret),
    .data_o     (chk_view),
    .known_o    (chk_known)
  );

  csr_atomic_check u_atomic_check (
    .clk          (clk),
    .reset        (reset),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_i    (rd_data_o),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .chk_addr_o   (chk_addr),
    .chk_view_i   (chk_view),
    .chk_known_i  (chk_known),
    .atomic_vio_o (atomic_vio_o)
  );

  assign evec_o   = mtvec;
  assign status_o = mstatus;
  // dynamic rounding mode for the FPU
  assign frm_o    = csr_pkg::csr_data_t'(fcsr[7:5]);

endmodule

/* include/csr_tb_vectors.svh */
// add_write:  op, address, data, random mask, value before commit, value after commit
// add_read:   address, expected read value
// add_exc:    cause, pc, load address, store address, address read after, expected
// add_retire: commit count, fflags, address read after, expected
// add_epc:    sret, expected epc_o
// add_rdchg:  address, data committed under the checkpoint, expected atomic_vio_o
task automatic load_vectors();
  // values out of reset
  add_read(CSR_MSTATUS, MSTATUS_RESET);
  add_read(CSR_MHARTID, HART_ID);
  add_read(CSR_SSTATUS, 64'h0000_0002_0000_0000);
  add_read(CSR_FCSR, 64'h0);
  add_read(CSR_MIE, 64'h0);
  add_read(CSR_MEPC, 64'h0);
  add_read(CSR_MINSTRET, 64'h0);
  add_read(12'h7C0, 64'h0);
  // commit and flush
  add_write(OP_WRC, CSR_MTVEC, 64'h0, '1, 64'h0, 64'h0);
  add_write(OP_WFC, CSR_MCAUSE, 64'h55, 64'h0, 64'h0, 64'h0);
  add_write(OP_WRC, CSR_MEPC, 64'h0, 64'hFFFF_FFFF_FFFF_FFFE, 64'h0, 64'h0);
  add_write(OP_WRC, CSR_MIE, '1, 64'h0, 64'h0, 64'hAAA);
  add_write(OP_WRC, CSR_SSTATUS, '1, 64'h0, 64'h0000_0002_0000_0000, 64'h0000_0002_000C_6122);
  add_read(CSR_MSTATUS, 64'h0000_000A_000C_6122);
  // floating-point fields
  add_write(OP_WRC, CSR_FCSR, 64'hDEAD_BEEF_0000_01A5, 64'h0, 64'h0, 64'hA5);
  add_read(CSR_FFLAGS, 64'h05);
  add_read(CSR_FRM, 64'h5);
  add_write(OP_WRC, CSR_FFLAGS, 64'hFFFF_FFFF_FFFF_FFFA, 64'h0, 64'h05, 64'h1A);
  add_read(CSR_FCSR, 64'hBA);
  add_write(OP_WRC, CSR_FRM, 64'hFFFF_FFFF_FFFF_FFF3, 64'h0, 64'h5, 64'h3);
  add_read(CSR_FCSR, 64'h7A);
  add_read(CSR_FRM, 64'h3);
  add_write(OP_WRC, CSR_FFLAGS, 64'h0, 64'h0, 64'h1A, 64'h0);
  add_retire(2'd0, 64'h01, CSR_FFLAGS, 64'h01);
  add_retire(2'd0, 64'hFFFF_FFFF_FFFF_FF04, CSR_FFLAGS, 64'h05);
  add_retire(2'd0, 64'h10, CSR_FFLAGS, 64'h15);
  add_read(CSR_FCSR, 64'h75);
  // traps
  add_exc(CAUSE_MISALIGNED_FETCH, 64'h8000_1000, 64'h2000, 64'h3000, CSR_MTVAL, 64'h8000_1000);
  add_read(CSR_MEPC, 64'h8000_1000);
  add_read(CSR_SEPC, 64'h8000_1000);
  add_read(CSR_MCAUSE, 64'h0);
  add_exc(CAUSE_FAULT_LOAD, 64'h8000_2004, 64'h4000_0008, 64'h5000, CSR_MTVAL, 64'h4000_0008);
  add_read(CSR_MCAUSE, 64'h5);
  add_exc(CAUSE_FAULT_STORE, 64'h8000_3008, 64'h7000, 64'h6000_0010, CSR_MTVAL, 64'h6000_0010);
  add_exc(5'd2, 64'h8000_4000, 64'h7100, 64'h7200, CSR_MTVAL, 64'h6000_0010);
  add_read(CSR_MCAUSE, 64'h2);
  add_read(CSR_MEPC, 64'h8000_4000);
  add_write(OP_WRC, CSR_SEPC, 64'h9000_0007, 64'h0, 64'h8000_4000, 64'h9000_0006);
  add_epc(1'b1, 64'h9000_0006);
  add_epc(1'b0, 64'h8000_4000);
  // retired instructions, four traps so far
  add_write(OP_WRC, CSR_MINSTRET, 64'd100, 64'h0, 64'd4, 64'd100);
  add_retire(2'd2, 64'h0, CSR_MINSTRET, 64'd102);
  add_retire(2'd1, 64'h0, CSR_MINSTRET, 64'd103);
  add_retire(2'd2, 64'h0, CSR_MINSTRET, 64'd105);
  add_exc(CAUSE_FAULT_FETCH, 64'h8000_5000, 64'h0, 64'h0, CSR_MINSTRET, 64'd106);
  add_read(CSR_MTVAL, 64'h8000_5000);
  // atomicity
  add_rdchg(CSR_MIE, 64'h0F0F, 64'h1);
  add_read(CSR_MIE, 64'hA0A);
endtask

/* tb/csr_file_tb.sv */
`timescale 1ns/1ps

module csr_file_tb;
  import csr_pkg::*;

  localparam int COMMIT_WIDTH = 2;
  localparam csr_data_t HART_ID = 64'h3;

  // row operations
  localparam int OP_WRC    = 0;
  localparam int OP_WFC    = 1;
  localparam int OP_READ   = 2;
  localparam int OP_EXC    = 3;
  localparam int OP_RETIRE = 4;
  localparam int OP_RDCHG  = 5;
  localparam int OP_EPC    = 6;

  typedef struct packed {
    int         op;
    csr_addr_t  addr;
    csr_data_t  data;
    csr_data_t  rmask;
    csr_data_t  exp_pre;
    csr_cause_t cause;
    csr_data_t  pc;
    csr_data_t  ld;
    csr_data_t  st;
    logic [1:0] count;
    csr_data_t  ffl;
    csr_data_t  expected;
  } row_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       flush_i;
  logic       wr_en_i;
  csr_addr_t  wr_addr_i;
  csr_data_t  wr_data_i;
  logic       commit_i;
  logic       rd_en_i;
  csr_addr_t  rd_addr_i;
  csr_data_t  rd_data_o;
  logic       exception_i;
  csr_data_t  exc_pc_i;
  csr_cause_t exc_cause_i;
  csr_data_t  ld_addr_i;
  csr_data_t  st_addr_i;
  logic       sret_i;
  logic [1:0] commit_count_i;
  csr_data_t  fflags_i;
  csr_data_t  hart_id_i;
  logic       atomic_vio_o;
  csr_data_t  epc_o;
  csr_data_t  evec_o;
  csr_data_t  status_o;
  csr_data_t  frm_o;

  row_t rows[$];
  int   errors = 0;
  int   cycles = 0;
  int   cycle_limit = 1000000;

  csr_file #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .flush_i        (flush_i),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .commit_i       (commit_i),
    .rd_en_i        (rd_en_i),
    .rd_addr_i      (rd_addr_i),
    .rd_data_o      (rd_data_o),
    .exception_i    (exception_i),
    .exc_pc_i       (exc_pc_i),
    .exc_cause_i    (exc_cause_i),
    .ld_addr_i      (ld_addr_i),
    .st_addr_i      (st_addr_i),
    .sret_i         (sret_i),
    .commit_count_i (commit_count_i),
    .fflags_i       (fflags_i),
    .hart_id_i      (hart_id_i),
    .atomic_vio_o   (atomic_vio_o),
    .epc_o          (epc_o),
    .evec_o         (evec_o),
    .status_o       (status_o),
    .frm_o          (frm_o)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input csr_data_t exp, input csr_data_t act);
    if (act !== exp)
    begin
      errors++;
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  function automatic row_t blank_row(input int op, input csr_addr_t addr);
    row_t r;
    r = '0;
    r.op = op;
    r.addr = addr;
    return r;
  endfunction

  task automatic add_write(input int op, input csr_addr_t addr, input csr_data_t data,
                           input csr_data_t rmask, input csr_data_t exp_pre,
                           input csr_data_t expected);
    row_t r;
    r = blank_row(op, addr);
    r.data = data;
    r.rmask = rmask;
    r.exp_pre = exp_pre;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic add_read(input csr_addr_t addr, input csr_data_t expected);
    row_t r;
    r = blank_row(OP_READ, addr);
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic add_exc(input csr_cause_t cause, input csr_data_t pc, input csr_data_t ld,
                         input csr_data_t st, input csr_addr_t addr,
                         input csr_data_t expected);
    row_t r;
    r = blank_row(OP_EXC, addr);
    r.cause = cause;
    r.pc = pc;
    r.ld = ld;
    r.st = st;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic add_retire(input logic [1:0] count, input csr_data_t ffl,
                            input csr_addr_t addr, input csr_data_t expected);
    row_t r;
    r = blank_row(OP_RETIRE, addr);
    r.count = count;
    r.ffl = ffl;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic add_epc(input logic sret, input csr_data_t expected);
    row_t r;
    r = blank_row(OP_EPC, 12'h0);
    r.data = {63'b0, sret};
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic add_rdchg(input csr_addr_t addr, input csr_data_t data,
                           input csr_data_t expected);
    row_t r;
    r = blank_row(OP_RDCHG, addr);
    r.data = data;
    r.expected = expected;
    rows.push_back(r);
  endtask

  `include "csr_tb_vectors.svh"

  // write stays pending, then commits in the following cycle
  task automatic do_write_commit(input row_t r);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_addr_i <= r.addr;
    wr_data_i <= r.data;
    rd_addr_i <= r.addr;
    @(negedge clk);
    check_value("rd_data_o before commit", r.exp_pre, rd_data_o);
    @(posedge clk);
    wr_en_i  <= 1'b0;
    commit_i <= 1'b1;
    @(negedge clk);
    check_value("rd_data_o in commit cycle", r.exp_pre, rd_data_o);
    @(posedge clk);
    commit_i <= 1'b0;
    @(negedge clk);
    check_value("rd_data_o after commit", r.expected, rd_data_o);
    if (r.addr == CSR_MTVEC)
      check_value("evec_o", r.expected, evec_o);
  endtask

  task automatic do_write_flush_commit(input row_t r);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_addr_i <= r.addr;
    wr_data_i <= r.data;
    rd_addr_i <= r.addr;
    @(posedge clk);
    wr_en_i <= 1'b0;
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i  <= 1'b0;
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
    @(negedge clk);
    check_value("rd_data_o after flushed commit", r.expected, rd_data_o);
  endtask

  // read with a checkpoint, then a flush drops the checkpoint
  task automatic do_read(input row_t r);
    @(posedge clk);
    rd_en_i   <= 1'b1;
    rd_addr_i <= r.addr;
    @(negedge clk);
    check_value("rd_data_o", r.expected, rd_data_o);
    if (r.addr == CSR_FRM)
      check_value("frm_o", r.expected, frm_o);
    if (r.addr == CSR_MSTATUS)
      check_value("status_o", r.expected, status_o);
    @(posedge clk);
    rd_en_i <= 1'b0;
    @(negedge clk);
    check_value("atomic_vio_o", 64'h0, {63'b0, atomic_vio_o});
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
  endtask

  task automatic do_exception(input row_t r);
    @(posedge clk);
    exception_i <= 1'b1;
    exc_cause_i <= r.cause;
    exc_pc_i    <= r.pc;
    ld_addr_i   <= r.ld;
    st_addr_i   <= r.st;
    rd_addr_i   <= r.addr;
    @(posedge clk);
    exception_i <= 1'b0;
    @(negedge clk);
    check_value("rd_data_o after exception", r.expected, rd_data_o);
  endtask

  task automatic do_retire(input row_t r);
    @(posedge clk);
    commit_count_i <= r.count;
    fflags_i       <= r.ffl;
    rd_addr_i      <= r.addr;
    @(posedge clk);
    commit_count_i <= 2'd0;
    fflags_i       <= '0;
    @(negedge clk);
    check_value("rd_data_o after retire", r.expected, rd_data_o);
  endtask

  task automatic do_epc(input row_t r);
    @(posedge clk);
    sret_i <= r.data[0];
    @(negedge clk);
    check_value("epc_o", r.expected, epc_o);
  endtask

  // the read samples the old value in the same cycle the write commits
  task automatic do_read_change(input row_t r);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_addr_i <= r.addr;
    wr_data_i <= r.data;
    @(posedge clk);
    wr_en_i   <= 1'b0;
    rd_en_i   <= 1'b1;
    rd_addr_i <= r.addr;
    commit_i  <= 1'b1;
    @(posedge clk);
    rd_en_i  <= 1'b0;
    commit_i <= 1'b0;
    @(negedge clk);
    check_value("atomic_vio_o after change", r.expected, {63'b0, atomic_vio_o});
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    check_value("atomic_vio_o after flush", 64'h0, {63'b0, atomic_vio_o});
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  initial
  begin
    row_t      r;
    int unsigned seed_val;
    csr_data_t rnd;
    reset          = 1'b1;
    flush_i        = 1'b0;
    wr_en_i        = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    commit_i       = 1'b0;
    rd_en_i        = 1'b0;
    rd_addr_i      = '0;
    exception_i    = 1'b0;
    exc_pc_i       = '0;
    exc_cause_i    = '0;
    ld_addr_i      = '0;
    st_addr_i      = '0;
    sret_i         = 1'b0;
    commit_count_i = 2'd0;
    fflags_i       = '0;
    hart_id_i      = HART_ID;
    seed_val = $urandom(57);
    load_vectors();
    cycle_limit = rows.size() * 8 + 50;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[i])
    begin
      r = rows[i];
      // random write data, expected bits follow the register's mask
      if (r.rmask != '0)
      begin
        rnd = {$urandom, $urandom};
        r.data = rnd;
        r.expected = (rnd & r.rmask) | r.expected;
      end
      case (r.op)
        OP_WRC:    do_write_commit(r);
        OP_WFC:    do_write_flush_commit(r);
        OP_READ:   do_read(r);
        OP_EXC:    do_exception(r);
        OP_RETIRE: do_retire(r);
        OP_RDCHG:  do_read_change(r);
        default:   do_epc(r);
      endcase
    end
    $display("Run complete: %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* csr_file.f */
+incdir+include
source/csr_pkg.sv
source/csr_write_stage.sv
source/csr_state.sv
source/csr_read_select.sv
source/csr_atomic_check.sv
source/csr_file.sv
tb/csr_file_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module csr_file_tb -f csr_file.f -o sim_csr_file

out=$(./obj_dir/sim_csr_file)
echo "$out"

if grep -q "Verification passed" <<< "$out"; then
  exit 0
fi
exit 1
